// File: lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// ----------------------------------------
// Queue geometry
// ----------------------------------------

// Entries in the age-ordered ring
`define LSU_QUEUE_DEPTH 8
// Index into the ring, log2 of the depth
`define LSU_IDX_W 3

// ----------------------------------------
// Datapath widths
// ----------------------------------------

// Processor tag
`define LSU_TAG_W 8
`define LSU_ADDR_W 64
`define LSU_DATA_W 64

`endif

// File: lsu_pkg.sv
`include "lsu_defines.svh"

package lsu_pkg;

  // Widths with a meaning of their own
  typedef logic [`LSU_TAG_W-1:0] tag_t;
  typedef logic [`LSU_ADDR_W-1:0] addr_t;
  typedef logic [`LSU_DATA_W-1:0] data_t;
  typedef logic [`LSU_IDX_W-1:0] idx_t;

  typedef enum logic {
    OP_LOAD,
    OP_STORE
  } op_e;

  // Cache port FSM
  typedef enum logic [1:0] {
    L1D_IDLE,
    L1D_REQ,
    L1D_WAIT
  } l1d_state_e;

  // ----------------------------------------
  // Queue entry
  // ----------------------------------------
  typedef struct packed {
    logic  valid;
    // Address and store data known
    logic  resolved;
    // Sent to the cache port
    logic  issued;
    // Result value is final
    logic  complete;
    op_e   op;
    tag_t  tag;
    addr_t addr;
    // Store data, later the result
    data_t value;
  } lsu_entry_t;

  typedef lsu_entry_t [`LSU_QUEUE_DEPTH-1:0] entry_vec_t;

  // ----------------------------------------
  // Processor side
  // ----------------------------------------
  typedef struct packed {
    tag_t tag;
    op_e  op;
  } instr_req_t;

  typedef struct packed {
    tag_t  tag;
    addr_t addr;
    data_t value;
  } data_req_t;

  // ----------------------------------------
  // Internal paths
  // ----------------------------------------
  typedef struct packed {
    idx_t  idx;
    data_t value;
  } fwd_t;

  typedef struct packed {
    idx_t  idx;
    op_e   op;
    addr_t addr;
    data_t value;
    tag_t  tag;
  } mem_req_t;

  // Already zeroed for writes
  typedef struct packed {
    tag_t  tag;
    data_t value;
  } mem_rsp_t;

  // ----------------------------------------
  // Cache and completion side
  // ----------------------------------------
  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t value;
    tag_t  tag;
  } l1d_req_t;

  typedef struct packed {
    tag_t  tag;
    data_t value;
  } l1d_rsp_t;

  typedef struct packed {
    tag_t  tag;
    data_t value;
  } completion_t;

endpackage

// File: lsu_entry_table.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_entry_table (
  input  logic                 clk_in,
  input  logic                 rst_N_in,
  input  logic                 instr_valid_in,
  input  lsu_pkg::instr_req_t  instr_in,
  input  logic                 data_valid_in,
  input  lsu_pkg::data_req_t   data_in,
  input  logic                 fwd_valid_in,
  input  lsu_pkg::fwd_t        fwd_in,
  input  logic                 mem_issue_valid_in,
  input  lsu_pkg::mem_req_t    mem_issue_in,
  input  logic                 mem_rsp_valid_in,
  input  lsu_pkg::mem_rsp_t    mem_rsp_in,
  input  logic                 retire_valid_in,
  input  lsu_pkg::idx_t        retire_idx_in,
  output logic                 instr_ready_out,
  output lsu_pkg::entry_vec_t  entries_out,
  output lsu_pkg::idx_t        head_idx_out
);

  lsu_pkg::entry_vec_t entries_q;
  lsu_pkg::idx_t       head_q;
  lsu_pkg::idx_t       tail_q;
  // One bit wider than the index so a full ring is visible
  logic [`LSU_IDX_W:0] count_q;

  logic                        alloc;
  logic                        pop;
  logic [`LSU_QUEUE_DEPTH-1:0] res_hit;
  logic [`LSU_QUEUE_DEPTH-1:0] rsp_hit;

  assign entries_out  = entries_q;
  assign head_idx_out = head_q;

  // Free tail slot and room left in the ring
  assign instr_ready_out = !entries_q[tail_q].valid &&
                           (count_q < (`LSU_IDX_W + 1)'(`LSU_QUEUE_DEPTH));
  assign alloc = instr_valid_in && instr_ready_out;

  // Head walks past retired slots, one per cycle
  assign pop = (count_q != '0) && !entries_q[head_q].valid;

  // ----------------------------------------
  // Tag matches
  // ----------------------------------------
  always_comb begin
    for (int i = 0; i < `LSU_QUEUE_DEPTH; i++) begin
      // Operands arrive for a waiting entry
      res_hit[i] = data_valid_in && entries_q[i].valid && !entries_q[i].resolved &&
                   (entries_q[i].tag == data_in.tag);
      // Cache result for the outstanding request
      rsp_hit[i] = mem_rsp_valid_in && entries_q[i].valid && entries_q[i].issued &&
                   !entries_q[i].complete && (entries_q[i].tag == mem_rsp_in.tag);
    end
  end

  // ----------------------------------------
  // Ring state
  // ----------------------------------------
  always_ff @(posedge clk_in or negedge rst_N_in) begin
    if (!rst_N_in) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      for (int i = 0; i < `LSU_QUEUE_DEPTH; i++) begin
        entries_q[i].valid    <= 1'b0;
        entries_q[i].resolved <= 1'b0;
        entries_q[i].issued   <= 1'b0;
        entries_q[i].complete <= 1'b0;
      end
    end else begin
      // New instruction at the tail
      if (alloc) begin
        entries_q[tail_q].valid    <= 1'b1;
        entries_q[tail_q].resolved <= 1'b0;
        entries_q[tail_q].issued   <= 1'b0;
        entries_q[tail_q].complete <= 1'b0;
        entries_q[tail_q].op       <= instr_in.op;
        entries_q[tail_q].tag      <= instr_in.tag;
        tail_q                     <= tail_q + 1'b1;
      end
      for (int i = 0; i < `LSU_QUEUE_DEPTH; i++) begin
        if (res_hit[i]) begin
          entries_q[i].resolved <= 1'b1;
          entries_q[i].addr     <= data_in.addr;
          // Loads get their value later
          if (entries_q[i].op == lsu_pkg::OP_STORE) begin
            entries_q[i].value <= data_in.value;
          end
        end
        if (rsp_hit[i]) begin
          entries_q[i].value    <= mem_rsp_in.value;
          entries_q[i].complete <= 1'b1;
        end
      end
      // Load served from an older store
      if (fwd_valid_in) begin
        entries_q[fwd_in.idx].value    <= fwd_in.value;
        entries_q[fwd_in.idx].complete <= 1'b1;
      end
      if (mem_issue_valid_in) begin
        entries_q[mem_issue_in.idx].issued <= 1'b1;
      end
      // Slot frees here, head catches up later
      if (retire_valid_in) begin
        entries_q[retire_idx_in].valid <= 1'b0;
      end
      if (pop) begin
        head_q <= head_q + 1'b1;
      end
      count_q <= count_q + (`LSU_IDX_W + 1)'(alloc) - (`LSU_IDX_W + 1)'(pop);
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // Processor only sends operands for one live, unresolved tag
  assert property (@(posedge clk_in) disable iff (!rst_N_in)
    data_valid_in |-> $onehot(res_hit))
    else $error("data strobe for tag %0h matched %0d entries", data_in.tag,
                $countones(res_hit));

  // Pointers meeting with entries in flight means the ring is full
  assert property (@(posedge clk_in) disable iff (!rst_N_in)
    alloc |-> (count_q == '0) || (tail_q != head_q))
    else $error("allocation into a full queue");

endmodule

// File: lsu_issue_select.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_issue_select (
  input  lsu_pkg::entry_vec_t entries_in,
  input  lsu_pkg::idx_t       head_idx_in,
  input  logic                mem_ready_in,
  output logic                fwd_valid_out,
  output lsu_pkg::fwd_t       fwd_out,
  output logic                mem_issue_valid_out,
  output lsu_pkg::mem_req_t   mem_issue_out
);

  always_comb begin
    lsu_pkg::idx_t i;
    lsu_pkg::idx_t ld_idx;
    lsu_pkg::idx_t old_idx;
    lsu_pkg::data_t hit_val;
    logic ld_found;
    logic st_pend;
    logic old_seen;
    logic hit;
    logic st_ready;
    int   ld_k;

    ld_found = 1'b0;
    st_pend  = 1'b0;
    old_seen = 1'b0;
    hit      = 1'b0;
    hit_val  = '0;
    ld_idx   = head_idx_in;
    old_idx  = head_idx_in;
    ld_k     = 0;

    // ----------------------------------------
    // Oldest ready load, head to tail
    // ----------------------------------------
    for (int k = 0; k < `LSU_QUEUE_DEPTH; k++) begin
      i = head_idx_in + lsu_pkg::idx_t'(k);
      if (entries_in[i].valid) begin
        // First live entry is the oldest
        if (!old_seen) begin
          old_seen = 1'b1;
          old_idx  = i;
        end
        // Unresolved store blocks every younger load
        if (entries_in[i].op == lsu_pkg::OP_STORE && !entries_in[i].resolved) begin
          st_pend = 1'b1;
        end else if (!ld_found && !st_pend && entries_in[i].op == lsu_pkg::OP_LOAD &&
                     entries_in[i].resolved && !entries_in[i].issued &&
                     !entries_in[i].complete) begin
          ld_found = 1'b1;
          ld_idx   = i;
          ld_k     = k;
        end
      end
    end

    // Nearest older store still holding its data, last match wins
    // A completed store is already in the cache and its value is zeroed
    for (int k = 0; k < `LSU_QUEUE_DEPTH; k++) begin
      i = head_idx_in + lsu_pkg::idx_t'(k);
      if (ld_found && k < ld_k && entries_in[i].valid &&
          entries_in[i].op == lsu_pkg::OP_STORE && !entries_in[i].complete &&
          entries_in[i].addr == entries_in[ld_idx].addr) begin
        hit     = 1'b1;
        hit_val = entries_in[i].value;
      end
    end

    // Writes leave only from the oldest slot, keeping program order
    st_ready = old_seen && entries_in[old_idx].op == lsu_pkg::OP_STORE &&
               entries_in[old_idx].resolved && !entries_in[old_idx].issued &&
               !entries_in[old_idx].complete;

    // ----------------------------------------
    // Outputs
    // ----------------------------------------
    fwd_valid_out = ld_found && hit;
    fwd_out.idx   = ld_idx;
    fwd_out.value = hit_val;

    mem_issue_valid_out = 1'b0;
    mem_issue_out.idx   = ld_idx;
    mem_issue_out.op    = entries_in[ld_idx].op;
    mem_issue_out.addr  = entries_in[ld_idx].addr;
    mem_issue_out.value = entries_in[ld_idx].value;
    mem_issue_out.tag   = entries_in[ld_idx].tag;
    if (ld_found) begin
      // Cache read only when nothing to forward
      mem_issue_valid_out = !hit && mem_ready_in;
    end else if (st_ready) begin
      mem_issue_valid_out = mem_ready_in;
      mem_issue_out.idx   = old_idx;
      mem_issue_out.op    = entries_in[old_idx].op;
      mem_issue_out.addr  = entries_in[old_idx].addr;
      mem_issue_out.value = entries_in[old_idx].value;
      mem_issue_out.tag   = entries_in[old_idx].tag;
    end
  end

  // One result path per cycle into the table
  always_comb begin
    assert final (!(fwd_valid_out && mem_issue_valid_out))
      else $error("forward and cache issue in the same cycle");
  end

endmodule

// File: lsu_l1d_port.sv
`timescale 1ns/1ps

module lsu_l1d_port (
  input  logic               clk_in,
  input  logic               rst_N_in,
  input  logic               mem_issue_valid_in,
  input  lsu_pkg::mem_req_t  mem_issue_in,
  input  logic               l1d_ready_in,
  input  logic               l1d_rsp_valid_in,
  input  lsu_pkg::l1d_rsp_t  l1d_rsp_in,
  output logic               mem_ready_out,
  output logic               l1d_req_valid_out,
  output lsu_pkg::l1d_req_t  l1d_req_out,
  output logic               mem_rsp_valid_out,
  output lsu_pkg::mem_rsp_t  mem_rsp_out
);

  lsu_pkg::l1d_state_e state_q;
  lsu_pkg::l1d_req_t   req_q;

  // Single outstanding request
  assign mem_ready_out     = (state_q == lsu_pkg::L1D_IDLE);
  assign l1d_req_valid_out = (state_q == lsu_pkg::L1D_REQ);
  assign l1d_req_out       = req_q;

  // ----------------------------------------
  // FSM and response strobe
  // ----------------------------------------
  always_ff @(posedge clk_in or negedge rst_N_in) begin
    if (!rst_N_in) begin
      state_q           <= lsu_pkg::L1D_IDLE;
      mem_rsp_valid_out <= 1'b0;
    end else begin
      mem_rsp_valid_out <= (state_q == lsu_pkg::L1D_WAIT) && l1d_rsp_valid_in;
      case (state_q)
        lsu_pkg::L1D_IDLE: if (mem_issue_valid_in) state_q <= lsu_pkg::L1D_REQ;
        // Hold until the cache takes it
        lsu_pkg::L1D_REQ:  if (l1d_ready_in) state_q <= lsu_pkg::L1D_WAIT;
        lsu_pkg::L1D_WAIT: if (l1d_rsp_valid_in) state_q <= lsu_pkg::L1D_IDLE;
        default:           state_q <= lsu_pkg::L1D_IDLE;
      endcase
    end
  end

  // Request latch and response capture
  always_ff @(posedge clk_in) begin
    if (state_q == lsu_pkg::L1D_IDLE && mem_issue_valid_in) begin
      req_q.we    <= (mem_issue_in.op == lsu_pkg::OP_STORE);
      req_q.addr  <= mem_issue_in.addr;
      req_q.value <= mem_issue_in.value;
      req_q.tag   <= mem_issue_in.tag;
    end
    if (l1d_rsp_valid_in) begin
      mem_rsp_out.tag   <= l1d_rsp_in.tag;
      // Stores complete with zero
      mem_rsp_out.value <= req_q.we ? '0 : l1d_rsp_in.value;
    end
  end

  // Cache answers only the request it accepted
  assert property (@(posedge clk_in) disable iff (!rst_N_in)
    l1d_rsp_valid_in |-> (state_q == lsu_pkg::L1D_WAIT) && (l1d_rsp_in.tag == req_q.tag))
    else $error("unexpected cache response tag %0h", l1d_rsp_in.tag);

  // Stalled request holds its fields
  assert property (@(posedge clk_in) disable iff (!rst_N_in)
    l1d_req_valid_out && !l1d_ready_in |=> l1d_req_valid_out && $stable(l1d_req_out))
    else $error("cache request changed before acceptance");

endmodule

// File: lsu_completion_select.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_completion_select (
  input  logic                 clk_in,
  input  logic                 rst_N_in,
  input  lsu_pkg::entry_vec_t  entries_in,
  input  lsu_pkg::idx_t        head_idx_in,
  output logic                 completion_valid_out,
  output lsu_pkg::completion_t completion_out,
  output logic                 retire_valid_out,
  output lsu_pkg::idx_t        retire_idx_out
);

  // Oldest finished entry, scanning from head
  always_comb begin
    lsu_pkg::idx_t i;
    logic found;

    found          = 1'b0;
    retire_idx_out = head_idx_in;
    for (int k = 0; k < `LSU_QUEUE_DEPTH; k++) begin
      i = head_idx_in + lsu_pkg::idx_t'(k);
      if (!found && entries_in[i].valid && entries_in[i].complete) begin
        found          = 1'b1;
        retire_idx_out = i;
      end
    end
    retire_valid_out = found;
  end

  always_ff @(posedge clk_in or negedge rst_N_in) begin
    if (!rst_N_in) begin
      completion_valid_out <= 1'b0;
    end else begin
      completion_valid_out <= retire_valid_out;
    end
  end

  // Result leaves as the slot is freed
  always_ff @(posedge clk_in) begin
    if (retire_valid_out) begin
      completion_out.tag   <= entries_in[retire_idx_out].tag;
      completion_out.value <= entries_in[retire_idx_out].value;
    end
  end

endmodule

// File: lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
  input  logic                 clk_in,
  input  logic                 rst_N_in,
  input  logic                 instr_valid_in,
  input  lsu_pkg::instr_req_t  instr_in,
  output logic                 instr_ready_out,
  input  logic                 data_valid_in,
  input  lsu_pkg::data_req_t   data_in,
  output logic                 l1d_req_valid_out,
  output lsu_pkg::l1d_req_t    l1d_req_out,
  input  logic                 l1d_ready_in,
  input  logic                 l1d_rsp_valid_in,
  input  lsu_pkg::l1d_rsp_t    l1d_rsp_in,
  output logic                 completion_valid_out,
  output lsu_pkg::completion_t completion_out
);

  // Queue view shared by both selectors
  lsu_pkg::entry_vec_t entries;
  lsu_pkg::idx_t       head_idx;

  // Result paths into the table
  logic                fwd_valid;
  lsu_pkg::fwd_t       fwd;
  logic                mem_issue_valid;
  lsu_pkg::mem_req_t   mem_issue;
  logic                mem_ready;
  logic                mem_rsp_valid;
  lsu_pkg::mem_rsp_t   mem_rsp;
  logic                retire_valid;
  lsu_pkg::idx_t       retire_idx;

  lsu_entry_table u_table (
    .clk_in             (clk_in),
    .rst_N_in           (rst_N_in),
    .instr_valid_in     (instr_valid_in),
    .instr_in           (instr_in),
    .data_valid_in      (data_valid_in),
    .data_in            (data_in),
    .fwd_valid_in       (fwd_valid),
    .fwd_in             (fwd),
    .mem_issue_valid_in (mem_issue_valid),
    .mem_issue_in       (mem_issue),
    .mem_rsp_valid_in   (mem_rsp_valid),
    .mem_rsp_in         (mem_rsp),
    .retire_valid_in    (retire_valid),
    .retire_idx_in      (retire_idx),
    .instr_ready_out    (instr_ready_out),
    .entries_out        (entries),
    .head_idx_out       (head_idx)
  );

  lsu_issue_select u_issue (
    .entries_in          (entries),
    .head_idx_in         (head_idx),
    .mem_ready_in        (mem_ready),
    .fwd_valid_out       (fwd_valid),
    .fwd_out             (fwd),
    .mem_issue_valid_out (mem_issue_valid),
    .mem_issue_out       (mem_issue)
  );

  lsu_l1d_port u_port (
    .clk_in             (clk_in),
    .rst_N_in           (rst_N_in),
    .mem_issue_valid_in (mem_issue_valid),
    .mem_issue_in       (mem_issue),
    .l1d_ready_in       (l1d_ready_in),
    .l1d_rsp_valid_in   (l1d_rsp_valid_in),
    .l1d_rsp_in         (l1d_rsp_in),
    .mem_ready_out      (mem_ready),
    .l1d_req_valid_out  (l1d_req_valid_out),
    .l1d_req_out        (l1d_req_out),
    .mem_rsp_valid_out  (mem_rsp_valid),
    .mem_rsp_out        (mem_rsp)
  );

  lsu_completion_select u_complete (
    .clk_in               (clk_in),
    .rst_N_in             (rst_N_in),
    .entries_in           (entries),
    .head_idx_in          (head_idx),
    .completion_valid_out (completion_valid_out),
    .completion_out       (completion_out),
    .retire_valid_out     (retire_valid),
    .retire_idx_out       (retire_idx)
  );

endmodule

// File: lsu_checker.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_checker (
  input  logic                 clk_in,
  input  logic                 rst_N_in,
  input  logic                 instr_valid,
  input  lsu_pkg::instr_req_t  instr,
  input  logic                 instr_ready,
  input  logic                 data_valid,
  input  lsu_pkg::data_req_t   data,
  input  logic                 l1d_req_valid,
  input  lsu_pkg::l1d_req_t    l1d_req,
  input  logic                 l1d_ready,
  input  logic                 completion_valid,
  input  lsu_pkg::completion_t completion,
  input  logic                 end_check,
  output int                   error_count
);

  localparam int MAX_OPS = 1024;
  localparam lsu_pkg::data_t FILL = 64'hA5A5_0000_5A5A_FFFF;

  // Program-order model, one slot per accepted instruction
  lsu_pkg::op_e   seq_op   [MAX_OPS];
  lsu_pkg::addr_t seq_addr [MAX_OPS];
  lsu_pkg::data_t seq_val  [MAX_OPS];
  logic           seq_done [MAX_OPS];
  int             tag_seq  [256];
  logic           tag_live [256];
  int             n_seq;
  int             outstanding;
  // Next store expected on the cache write path
  int             wr_ptr;
  logic           started;
  // Cache request seen stalled at the previous edge
  logic              req_wait;
  lsu_pkg::l1d_req_t req_prev;

  // Latest earlier store to the same address, else the fill rule
  function automatic lsu_pkg::data_t load_value(input int s);
    for (int j = s - 1; j >= 0; j--) begin
      if (seq_op[j] == lsu_pkg::OP_STORE && seq_addr[j] == seq_addr[s]) begin
        return seq_val[j];
      end
    end
    return seq_addr[s] ^ FILL;
  endfunction

  task automatic report(input string name, input logic [63:0] exp_v, input logic [63:0] act_v);
    error_count++;
    $display("** Error %s: expected %h actual %h", name, exp_v, act_v);
  endtask

  initial begin
    error_count = 0;
    n_seq       = 0;
    outstanding = 0;
    wr_ptr      = 0;
    started     = 1'b0;
    req_wait    = 1'b0;
    for (int t = 0; t < 256; t++) begin
      tag_live[t] = 1'b0;
      tag_seq[t]  = 0;
    end
  end

  always @(posedge clk_in) begin
    int s;
    logic older_hit;
    if (rst_N_in) begin
      // ----------------------------------------
      // State just after reset
      // ----------------------------------------
      if (!started) begin
        started = 1'b1;
        if (!instr_ready || l1d_req_valid || completion_valid) begin
          error_count++;
          $display("Outputs not in their reset state after reset release");
        end
      end
      // Full ring must hold off the processor
      if (outstanding == `LSU_QUEUE_DEPTH && instr_ready) begin
        error_count++;
        $display("instr_ready_out high with %0d entries in flight", outstanding);
      end
      // Stalled cache request holds valid and fields until taken
      if (req_wait && (!l1d_req_valid || l1d_req != req_prev)) begin
        error_count++;
        $display("Cache request dropped or changed before the cache accepted it");
      end
      req_wait = l1d_req_valid && !l1d_ready;
      req_prev = l1d_req;
      if (instr_valid && instr_ready) begin
        if (tag_live[instr.tag] || n_seq >= MAX_OPS) begin
          error_count++;
          $display("Instruction tag %0h accepted while still live", instr.tag);
        end else begin
          seq_op[n_seq]      = instr.op;
          seq_done[n_seq]    = 1'b0;
          tag_seq[instr.tag] = n_seq;
          tag_live[instr.tag] = 1'b1;
          n_seq++;
          outstanding++;
        end
      end
      if (data_valid && tag_live[data.tag]) begin
        seq_addr[tag_seq[data.tag]] = data.addr;
        seq_val[tag_seq[data.tag]]  = data.value;
      end
      // ----------------------------------------
      // Cache requests at acceptance
      // ----------------------------------------
      if (l1d_req_valid && l1d_ready) begin
        if (l1d_req.we) begin
          while (wr_ptr < n_seq && seq_op[wr_ptr] != lsu_pkg::OP_STORE) begin
            wr_ptr++;
          end
          if (wr_ptr >= n_seq) begin
            error_count++;
            $display("Cache write with no store left in program order");
          end else begin
            if (l1d_req.addr != seq_addr[wr_ptr]) begin
              report("write_addr", seq_addr[wr_ptr], l1d_req.addr);
            end
            if (l1d_req.value != seq_val[wr_ptr]) begin
              report("write_value", seq_val[wr_ptr], l1d_req.value);
            end
            wr_ptr++;
          end
        end else if (!tag_live[l1d_req.tag]) begin
          error_count++;
          $display("Cache read for tag %0h which is not in flight", l1d_req.tag);
        end else begin
          s = tag_seq[l1d_req.tag];
          if (l1d_req.addr != seq_addr[s]) begin
            report("read_addr", seq_addr[s], l1d_req.addr);
          end
          // A pending older store to this address should have forwarded
          older_hit = 1'b0;
          for (int j = 0; j < s; j++) begin
            if (!seq_done[j] && seq_op[j] == lsu_pkg::OP_STORE &&
                seq_addr[j] == seq_addr[s]) begin
              older_hit = 1'b1;
            end
          end
          if (older_hit) begin
            error_count++;
            $display("Cache read for tag %0h instead of a forward", l1d_req.tag);
          end
        end
      end
      // ----------------------------------------
      // Completions
      // ----------------------------------------
      if (completion_valid) begin
        if (!tag_live[completion.tag]) begin
          error_count++;
          $display("Completion for tag %0h which is not in flight", completion.tag);
        end else begin
          s = tag_seq[completion.tag];
          if (seq_op[s] == lsu_pkg::OP_LOAD) begin
            if (completion.value != load_value(s)) begin
              report("load_value", load_value(s), completion.value);
            end
          end else if (completion.value != '0) begin
            report("store_value", 64'h0, completion.value);
          end
          seq_done[s] = 1'b1;
          tag_live[completion.tag] = 1'b0;
          outstanding--;
        end
      end
      if (end_check) begin
        for (int j = 0; j < n_seq; j++) begin
          if (!seq_done[j]) begin
            error_count++;
            $display("Operation %0d never completed", j);
          end
        end
      end
    end
  end

endmodule

// File: lsu_tb.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_tb;

  localparam int CYCLE_LIMIT = 200 * 40 + 2000;
  localparam lsu_pkg::data_t FILL = 64'hA5A5_0000_5A5A_FFFF;

  logic                 clk_in;
  logic                 rst_N_in;
  logic                 instr_valid_in;
  lsu_pkg::instr_req_t  instr_in;
  logic                 instr_ready_out;
  logic                 data_valid_in;
  lsu_pkg::data_req_t   data_in;
  logic                 l1d_req_valid_out;
  lsu_pkg::l1d_req_t    l1d_req_out;
  logic                 l1d_ready_in;
  logic                 l1d_rsp_valid_in;
  lsu_pkg::l1d_rsp_t    l1d_rsp_in;
  logic                 completion_valid_out;
  lsu_pkg::completion_t completion_out;
  logic                 end_check;
  int                   error_count;

  int                   cycles;
  int                   accepted;
  int                   comp_count;
  logic                 hold_ready;
  // Cache contents written so far, the rest follows the fill rule
  lsu_pkg::data_t       mem [lsu_pkg::addr_t];
  lsu_pkg::tag_t        pend_tag [$];

  lsu_top dut_i (.*);

  lsu_checker chk_i (
    .clk_in (clk_in), .rst_N_in (rst_N_in),
    .instr_valid (instr_valid_in), .instr (instr_in), .instr_ready (instr_ready_out),
    .data_valid (data_valid_in), .data (data_in),
    .l1d_req_valid (l1d_req_valid_out), .l1d_req (l1d_req_out), .l1d_ready (l1d_ready_in),
    .completion_valid (completion_valid_out), .completion (completion_out),
    .end_check (end_check), .error_count (error_count)
  );

  initial begin
    clk_in = 1'b0;
    forever #2 clk_in = ~clk_in;
  end

  // Run limit and completion count
  always @(posedge clk_in) begin
    cycles <= cycles + 1;
    if (completion_valid_out) comp_count <= comp_count + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles with %0d of %0d completed", cycles, comp_count,
               accepted);
      $display("test failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Cache responder
  // ----------------------------------------
  initial begin
    lsu_pkg::l1d_req_t req;
    l1d_ready_in     = 1'b0;
    l1d_rsp_valid_in = 1'b0;
    l1d_rsp_in       = '0;
    @(posedge rst_N_in);
    forever begin
      do @(posedge clk_in); while (!l1d_req_valid_out || hold_ready);
      repeat ($urandom % 4) @(posedge clk_in);
      #1 l1d_ready_in = 1'b1;
      @(posedge clk_in);
      req = l1d_req_out;
      if (req.we) mem[req.addr] = req.value;
      #1 l1d_ready_in = 1'b0;
      // Response 1 to 3 cycles after acceptance
      repeat ($urandom % 3) begin
        @(posedge clk_in);
        #1;
      end
      l1d_rsp_in.tag   = req.tag;
      l1d_rsp_in.value = mem.exists(req.addr) ? mem[req.addr] : (req.addr ^ FILL);
      l1d_rsp_valid_in = 1'b1;
      @(posedge clk_in);
      #1 l1d_rsp_valid_in = 1'b0;
    end
  end

  // Hold the request until the DUT takes it
  task automatic send_instr(input lsu_pkg::tag_t tag, input lsu_pkg::op_e op);
    instr_valid_in = 1'b1;
    instr_in.tag   = tag;
    instr_in.op    = op;
    do @(posedge clk_in); while (!instr_ready_out);
    #1 instr_valid_in = 1'b0;
    accepted++;
    pend_tag.push_back(tag);
  endtask

  task automatic send_data(input lsu_pkg::tag_t tag, input lsu_pkg::addr_t addr,
                           input lsu_pkg::data_t value);
    data_valid_in = 1'b1;
    data_in.tag   = tag;
    data_in.addr  = addr;
    data_in.value = value;
    @(posedge clk_in);
    #1 data_valid_in = 1'b0;
  endtask

  // Operands for one pending tag chosen at random
  task automatic resolve_random();
    int j;
    j = $urandom % pend_tag.size();
    send_data(pend_tag[j], 64'h1000 + 64'(8 * ($urandom % 4)), {$urandom, $urandom});
    pend_tag.delete(j);
  endtask

  task automatic wait_completions(input int target);
    while (comp_count < target) begin
      @(posedge clk_in);
      #1;
    end
  endtask

  initial begin
    int issued;
    lsu_pkg::tag_t next_tag;
    void'($urandom(32'h1294_cf85));
    cycles         = 0;
    accepted       = 0;
    comp_count     = 0;
    hold_ready     = 1'b0;
    end_check      = 1'b0;
    instr_valid_in = 1'b0;
    instr_in       = '0;
    data_valid_in  = 1'b0;
    data_in        = '0;
    rst_N_in       = 1'b0;
    repeat (8) @(posedge clk_in);
    #1 rst_N_in = 1'b1;
    @(posedge clk_in);
    #1;
    // Forwarding with the cache stalled
    hold_ready = 1'b1;
    send_instr(8'd1, lsu_pkg::OP_STORE);
    send_instr(8'd2, lsu_pkg::OP_LOAD);
    pend_tag.delete();
    send_data(8'd1, 64'h2000, 64'h0123_4567_89AB_CDEF);
    send_data(8'd2, 64'h2000, 64'h0);
    wait_completions(1);
    hold_ready = 1'b0;
    wait_completions(accepted);
    // Full queue with operands withheld
    for (int k = 0; k < `LSU_QUEUE_DEPTH; k++) begin
      send_instr(lsu_pkg::tag_t'(16 + k), lsu_pkg::op_e'($urandom % 2));
    end
    repeat (4) @(posedge clk_in);
    #1;
    while (pend_tag.size() > 0) resolve_random();
    wait_completions(accepted);
    while (!instr_ready_out) begin
      @(posedge clk_in);
      #1;
    end
    // Random traffic over four addresses
    issued = 0;
    next_tag = 8'd32;
    while (issued < 200 || pend_tag.size() > 0) begin
      if (issued < 200 && (pend_tag.size() == 0 || (instr_ready_out && $urandom % 2 == 1))) begin
        send_instr(next_tag, lsu_pkg::op_e'($urandom % 2));
        next_tag++;
        issued++;
      end else begin
        resolve_random();
      end
    end
    wait_completions(accepted);
    end_check = 1'b1;
    @(posedge clk_in);
    #1 end_check = 1'b0;
    @(posedge clk_in);
    #1;
    $display("Checks finished with %0d errors over %0d operations", error_count, accepted);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+.
lsu_pkg.sv
lsu_entry_table.sv
lsu_issue_select.sv
lsu_l1d_port.sv
lsu_completion_select.sv
lsu_top.sv
lsu_checker.sv
lsu_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f files.f --top-module lsu_tb -o lsu_sim
./obj_dir/lsu_sim | tee sim.log

if grep -qx "test passed" sim.log; then
  exit 0
else
  echo "Simulation did not pass, see sim.log"
  exit 1
fi
